/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// word and address geometry of the processor
	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;

	// address layout is {tag, index, offset}
	localparam int TAG_W    = 11;
	localparam int INDEX_W  = 3;
	localparam int OFFSET_W = 2;

	// direct-mapped cache shape
	localparam int LINE_COUNT = 8;
	localparam int LINE_WORDS = 4;

	// line address on the memory bus drops the word offset
	localparam int LINE_ADDR_W = TAG_W + INDEX_W;

	// shared main memory
	localparam int MEM_DEPTH = 256;

	// idle cycles between command accept and the first beat
	localparam int MEM_WAIT = 4;

	// cache controller states
	typedef enum logic [1:0] {
		CS_IDLE,
		CS_WRITEBACK,
		CS_REFILL
	} cache_state_t;

	// line transfer command toward main memory
	typedef enum logic [1:0] {
		MC_NONE,
		MC_READ,
		MC_WRITE
	} mem_cmd_t;

endpackage

`default_nettype wire

/* icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
	input  wire                                 clk,
	input  wire                                 reset_n,
	input  wire                                 i_read,
	input  wire [cache_pkg::ADDR_W-1:0]         i_addr,
	output logic [cache_pkg::WORD_W-1:0]        o_data,
	output logic                                o_busy,
	output cache_pkg::mem_cmd_t                 o_mem_cmd,
	output logic [cache_pkg::LINE_ADDR_W-1:0]   o_mem_line_addr,
	input  wire                                 i_mem_beat,
	input  wire [cache_pkg::OFFSET_W-1:0]       i_mem_beat_idx,
	input  wire [cache_pkg::WORD_W-1:0]         i_mem_rdata,
	input  wire                                 i_mem_done
);

	import cache_pkg::*;

	logic [TAG_W-1:0]      tag_q  [LINE_COUNT];
	logic [WORD_W-1:0]     data_q [LINE_COUNT][LINE_WORDS];
	logic [LINE_COUNT-1:0] valid_q;
	cache_state_t          state_q;

	logic [TAG_W-1:0]    addr_tag;
	logic [INDEX_W-1:0]  addr_idx;
	logic [OFFSET_W-1:0] addr_off;
	logic                hit;
	logic                refill_beat;
	logic                refill_done;

	assign addr_tag = i_addr[ADDR_W-1 -: TAG_W];
	assign addr_idx = i_addr[OFFSET_W +: INDEX_W];
	assign addr_off = i_addr[OFFSET_W-1:0];

	// lookup against the indexed line only
	assign hit = valid_q[addr_idx] && (tag_q[addr_idx] == addr_tag);

	assign o_busy = i_read && (!hit || (state_q != CS_IDLE));

	// the held request address names the line being fetched
	assign o_mem_cmd       = (state_q == CS_REFILL) ? MC_READ : MC_NONE;
	assign o_mem_line_addr = {addr_tag, addr_idx};

	assign refill_beat = (state_q == CS_REFILL) && i_mem_beat;
	assign refill_done = (state_q == CS_REFILL) && i_mem_done;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= CS_IDLE;
			valid_q <= '0;
		end else begin
			case (state_q)
				CS_IDLE: begin
					if (i_read && !hit) begin
						state_q <= CS_REFILL;
					end
				end
				CS_REFILL: begin
					// line becomes valid with its last beat
					if (i_mem_done) begin
						valid_q[addr_idx] <= 1'b1;
						state_q           <= CS_IDLE;
					end
				end
				default: begin
					state_q <= CS_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (refill_beat) begin
			data_q[addr_idx][i_mem_beat_idx] <= i_mem_rdata;
		end
		if (refill_done) begin
			tag_q[addr_idx] <= addr_tag;
		end
	end

	// read word is captured on the completing edge
	always_ff @(posedge clk) begin
		if (i_read && !o_busy) begin
			o_data <= data_q[addr_idx][addr_off];
		end
	end

endmodule

`default_nettype wire

/* dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache (
	input  wire                                 clk,
	input  wire                                 reset_n,
	input  wire                                 i_read,
	input  wire                                 i_write,
	input  wire [cache_pkg::ADDR_W-1:0]         i_addr,
	input  wire [cache_pkg::WORD_W-1:0]         i_wdata,
	output logic [cache_pkg::WORD_W-1:0]        o_rdata,
	output logic                                o_busy,
	output cache_pkg::mem_cmd_t                 o_mem_cmd,
	output logic [cache_pkg::LINE_ADDR_W-1:0]   o_mem_line_addr,
	output logic [cache_pkg::WORD_W-1:0]        o_mem_wdata,
	input  wire                                 i_mem_beat,
	input  wire [cache_pkg::OFFSET_W-1:0]       i_mem_beat_idx,
	input  wire [cache_pkg::WORD_W-1:0]         i_mem_rdata,
	input  wire                                 i_mem_done
);

	import cache_pkg::*;

	logic [TAG_W-1:0]      tag_q  [LINE_COUNT];
	logic [WORD_W-1:0]     data_q [LINE_COUNT][LINE_WORDS];
	logic [LINE_COUNT-1:0] valid_q;
	logic [LINE_COUNT-1:0] dirty_q;
	cache_state_t          state_q;

	logic [TAG_W-1:0]    addr_tag;
	logic [INDEX_W-1:0]  addr_idx;
	logic [OFFSET_W-1:0] addr_off;
	logic                req;
	logic                hit;
	logic                victim_dirty;
	logic                access;
	logic                refill_beat;
	logic                refill_done;

	assign addr_tag = i_addr[ADDR_W-1 -: TAG_W];
	assign addr_idx = i_addr[OFFSET_W +: INDEX_W];
	assign addr_off = i_addr[OFFSET_W-1:0];

	assign req          = i_read || i_write;
	assign hit          = valid_q[addr_idx] && (tag_q[addr_idx] == addr_tag);
	assign victim_dirty = valid_q[addr_idx] && dirty_q[addr_idx];

	assign o_busy = req && (!hit || (state_q != CS_IDLE));

	// completing edge of a read or write hit
	assign access = req && !o_busy;

	always_comb begin
		case (state_q)
			CS_WRITEBACK: o_mem_cmd = MC_WRITE;
			CS_REFILL:    o_mem_cmd = MC_READ;
			default:      o_mem_cmd = MC_NONE;
		endcase
	end

	// write-back targets the victim's stored tag, refill the requested one
	assign o_mem_line_addr = (state_q == CS_WRITEBACK) ? {tag_q[addr_idx], addr_idx}
	                                                   : {addr_tag, addr_idx};

	// victim word for whichever beat memory is on
	assign o_mem_wdata = data_q[addr_idx][i_mem_beat_idx];

	assign refill_beat = (state_q == CS_REFILL) && i_mem_beat;
	assign refill_done = (state_q == CS_REFILL) && i_mem_done;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= CS_IDLE;
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			case (state_q)
				CS_IDLE: begin
					if (req && !hit) begin
						if (victim_dirty) begin
							state_q <= CS_WRITEBACK;
						end else begin
							state_q <= CS_REFILL;
						end
					end else if (i_write && hit) begin
						dirty_q[addr_idx] <= 1'b1;
					end
				end
				CS_WRITEBACK: begin
					// memory now holds the victim, fetch the new line next
					if (i_mem_done) begin
						dirty_q[addr_idx] <= 1'b0;
						state_q           <= CS_REFILL;
					end
				end
				CS_REFILL: begin
					if (i_mem_done) begin
						valid_q[addr_idx] <= 1'b1;
						dirty_q[addr_idx] <= 1'b0;
						state_q           <= CS_IDLE;
					end
				end
				default: begin
					state_q <= CS_IDLE;
				end
			endcase
		end
	end

	// line words come from refill beats or from a write hit
	always_ff @(posedge clk) begin
		if (refill_beat) begin
			data_q[addr_idx][i_mem_beat_idx] <= i_mem_rdata;
		end else if (access && i_write) begin
			data_q[addr_idx][addr_off] <= i_wdata;
		end
		if (refill_done) begin
			tag_q[addr_idx] <= addr_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (access && i_read) begin
			o_rdata <= data_q[addr_idx][addr_off];
		end
	end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire                                 clk,
	input  wire                                 reset_n,
	input  wire cache_pkg::mem_cmd_t            i_ic_cmd,
	input  wire [cache_pkg::LINE_ADDR_W-1:0]    i_ic_line_addr,
	output logic                                o_ic_beat,
	output logic                                o_ic_done,
	input  wire cache_pkg::mem_cmd_t            i_dc_cmd,
	input  wire [cache_pkg::LINE_ADDR_W-1:0]    i_dc_line_addr,
	input  wire [cache_pkg::WORD_W-1:0]         i_dc_wdata,
	output logic                                o_dc_beat,
	output logic                                o_dc_done,
	output cache_pkg::mem_cmd_t                 o_mem_cmd,
	output logic [cache_pkg::LINE_ADDR_W-1:0]   o_mem_line_addr,
	output logic [cache_pkg::WORD_W-1:0]        o_mem_wdata,
	input  wire                                 i_mem_beat,
	input  wire [cache_pkg::OFFSET_W-1:0]       i_mem_beat_idx,
	input  wire [cache_pkg::WORD_W-1:0]         i_mem_rdata,
	input  wire                                 i_mem_done,
	output logic [cache_pkg::OFFSET_W-1:0]      o_beat_idx,
	output logic [cache_pkg::WORD_W-1:0]        o_rdata
);

	import cache_pkg::*;

	logic gnt_ic_q;
	logic gnt_dc_q;

	// grant is locked for a whole line, data side wins a tie
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			gnt_ic_q <= 1'b0;
			gnt_dc_q <= 1'b0;
		end else if (gnt_ic_q || gnt_dc_q) begin
			if (i_mem_done) begin
				gnt_ic_q <= 1'b0;
				gnt_dc_q <= 1'b0;
			end
		end else if (i_dc_cmd != MC_NONE) begin
			gnt_dc_q <= 1'b1;
		end else if (i_ic_cmd != MC_NONE) begin
			gnt_ic_q <= 1'b1;
		end
	end

	always_comb begin
		if (gnt_dc_q) begin
			o_mem_cmd       = i_dc_cmd;
			o_mem_line_addr = i_dc_line_addr;
		end else if (gnt_ic_q) begin
			o_mem_cmd       = i_ic_cmd;
			o_mem_line_addr = i_ic_line_addr;
		end else begin
			o_mem_cmd       = MC_NONE;
			o_mem_line_addr = '0;
		end
	end

	// only the data cache ever writes
	assign o_mem_wdata = i_dc_wdata;

	assign o_ic_beat = gnt_ic_q && i_mem_beat;
	assign o_ic_done = gnt_ic_q && i_mem_done;
	assign o_dc_beat = gnt_dc_q && i_mem_beat;
	assign o_dc_done = gnt_dc_q && i_mem_done;

	assign o_beat_idx = i_mem_beat_idx;
	assign o_rdata    = i_mem_rdata;

endmodule

`default_nettype wire

/* main_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module main_memory (
	input  wire                                 clk,
	input  wire                                 reset_n,
	input  wire cache_pkg::mem_cmd_t            i_cmd,
	input  wire [cache_pkg::LINE_ADDR_W-1:0]    i_line_addr,
	input  wire [cache_pkg::WORD_W-1:0]         i_wdata,
	output logic                                o_beat,
	output logic [cache_pkg::OFFSET_W-1:0]      o_beat_idx,
	output logic [cache_pkg::WORD_W-1:0]        o_rdata,
	output logic                                o_done
);

	import cache_pkg::*;

	logic [WORD_W-1:0]                            mem_q [MEM_DEPTH];
	mem_cmd_t                                     cmd_q;
	logic [$clog2(MEM_WAIT+LINE_WORDS)-1:0]       cnt_q;
	logic [LINE_ADDR_W-1:0]                       line_q;
	logic [$clog2(MEM_DEPTH)-1:0]                 word_addr;

	// wait phase first, then one beat per count
	assign o_beat     = (cmd_q != MC_NONE) && (cnt_q >= MEM_WAIT);
	assign o_beat_idx = OFFSET_W'(cnt_q - MEM_WAIT);
	assign o_done     = o_beat && (o_beat_idx == OFFSET_W'(LINE_WORDS - 1));

	// upper line address bits alias
	assign word_addr = {line_q[$clog2(MEM_DEPTH)-OFFSET_W-1:0], o_beat_idx};
	assign o_rdata   = mem_q[word_addr];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cmd_q <= MC_NONE;
			cnt_q <= '0;
		end else if (cmd_q == MC_NONE) begin
			if (i_cmd != MC_NONE) begin
				cmd_q <= i_cmd;
				cnt_q <= '0;
			end
		end else begin
			cnt_q <= cnt_q + 1'b1;
			if (o_done) begin
				cmd_q <= MC_NONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_q == MC_NONE) begin
			line_q <= i_line_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < MEM_DEPTH; i++) begin
				mem_q[i] <= '0;
			end
		end else if (o_beat && (cmd_q == MC_WRITE)) begin
			mem_q[word_addr] <= i_wdata;
		end
	end

endmodule

`default_nettype wire

/* mem_system.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_system (
	input  wire                                 clk,
	input  wire                                 reset_n,
	input  wire                                 i_if_read,
	input  wire [cache_pkg::ADDR_W-1:0]         i_if_addr,
	output logic [cache_pkg::WORD_W-1:0]        o_if_data,
	output logic                                o_if_busy,
	input  wire                                 i_d_read,
	input  wire                                 i_d_write,
	input  wire [cache_pkg::ADDR_W-1:0]         i_d_addr,
	input  wire [cache_pkg::WORD_W-1:0]         i_d_wdata,
	output logic [cache_pkg::WORD_W-1:0]        o_d_rdata,
	output logic                                o_d_busy
);

	import cache_pkg::*;

	// cache side of the arbiter
	mem_cmd_t               ic_cmd;
	logic [LINE_ADDR_W-1:0] ic_line_addr;
	logic                   ic_beat;
	logic                   ic_done;
	mem_cmd_t               dc_cmd;
	logic [LINE_ADDR_W-1:0] dc_line_addr;
	logic [WORD_W-1:0]      dc_wdata;
	logic                   dc_beat;
	logic                   dc_done;
	logic [OFFSET_W-1:0]    arb_beat_idx;
	logic [WORD_W-1:0]      arb_rdata;

	// memory side of the arbiter
	mem_cmd_t               mem_cmd;
	logic [LINE_ADDR_W-1:0] mem_line_addr;
	logic [WORD_W-1:0]      mem_wdata;
	logic                   mem_beat;
	logic [OFFSET_W-1:0]    mem_beat_idx;
	logic [WORD_W-1:0]      mem_rdata;
	logic                   mem_done;

	icache u_icache (
		.clk             (clk),
		.reset_n         (reset_n),
		.i_read          (i_if_read),
		.i_addr          (i_if_addr),
		.o_data          (o_if_data),
		.o_busy          (o_if_busy),
		.o_mem_cmd       (ic_cmd),
		.o_mem_line_addr (ic_line_addr),
		.i_mem_beat      (ic_beat),
		.i_mem_beat_idx  (arb_beat_idx),
		.i_mem_rdata     (arb_rdata),
		.i_mem_done      (ic_done)
	);

	dcache u_dcache (
		.clk             (clk),
		.reset_n         (reset_n),
		.i_read          (i_d_read),
		.i_write         (i_d_write),
		.i_addr          (i_d_addr),
		.i_wdata         (i_d_wdata),
		.o_rdata         (o_d_rdata),
		.o_busy          (o_d_busy),
		.o_mem_cmd       (dc_cmd),
		.o_mem_line_addr (dc_line_addr),
		.o_mem_wdata     (dc_wdata),
		.i_mem_beat      (dc_beat),
		.i_mem_beat_idx  (arb_beat_idx),
		.i_mem_rdata     (arb_rdata),
		.i_mem_done      (dc_done)
	);

	mem_arbiter u_arbiter (
		.clk             (clk),
		.reset_n         (reset_n),
		.i_ic_cmd        (ic_cmd),
		.i_ic_line_addr  (ic_line_addr),
		.o_ic_beat       (ic_beat),
		.o_ic_done       (ic_done),
		.i_dc_cmd        (dc_cmd),
		.i_dc_line_addr  (dc_line_addr),
		.i_dc_wdata      (dc_wdata),
		.o_dc_beat       (dc_beat),
		.o_dc_done       (dc_done),
		.o_mem_cmd       (mem_cmd),
		.o_mem_line_addr (mem_line_addr),
		.o_mem_wdata     (mem_wdata),
		.i_mem_beat      (mem_beat),
		.i_mem_beat_idx  (mem_beat_idx),
		.i_mem_rdata     (mem_rdata),
		.i_mem_done      (mem_done),
		.o_beat_idx      (arb_beat_idx),
		.o_rdata         (arb_rdata)
	);

	main_memory u_memory (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_cmd       (mem_cmd),
		.i_line_addr (mem_line_addr),
		.i_wdata     (mem_wdata),
		.o_beat      (mem_beat),
		.o_beat_idx  (mem_beat_idx),
		.o_rdata     (mem_rdata),
		.o_done      (mem_done)
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
	end

	// 4 ns period
	always #2 o_clk = ~o_clk;

endmodule

`default_nettype wire

/* mem_system_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_system_props (
	input wire                          clk,
	input wire                          reset_n,
	input wire                          i_gnt_ic,
	input wire                          i_gnt_dc,
	input wire                          i_mem_done,
	input wire cache_pkg::mem_cmd_t     i_mem_cmd,
	input wire cache_pkg::cache_state_t i_ic_state,
	input wire cache_pkg::cache_state_t i_dc_state,
	input wire                          i_if_read,
	input wire                          i_d_read,
	input wire                          i_d_write,
	input wire                          i_if_busy,
	input wire                          i_d_busy
);

	import cache_pkg::*;

	a_one_grant: assert property (@(posedge clk) disable iff (!reset_n)
		!(i_gnt_ic && i_gnt_dc))
		else $error("arbiter granted both caches");

	a_done_granted: assert property (@(posedge clk) disable iff (!reset_n)
		i_mem_done |-> ((i_gnt_ic || i_gnt_dc) && (i_mem_cmd != MC_NONE)))
		else $error("memory done without a granted command");

	// first cycle out of reset with no request
	a_idle_after_reset: assert property (@(posedge clk)
		($rose(reset_n) && !i_if_read && !i_d_read && !i_d_write) |->
		(!i_if_busy && !i_d_busy && (i_ic_state == CS_IDLE) && (i_dc_state == CS_IDLE)
			&& !i_gnt_ic && !i_gnt_dc && (i_mem_cmd == MC_NONE)))
		else $error("busy, grant or controller not idle right after reset");

endmodule

`default_nettype wire

/* tb_mem_system.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;

	import cache_pkg::*;

	localparam int TIMEOUT = 200;

	logic                clk;
	logic                reset_n;
	logic                i_if_read;
	logic [ADDR_W-1:0]   i_if_addr;
	logic [WORD_W-1:0]   o_if_data;
	logic                o_if_busy;
	logic                i_d_read;
	logic                i_d_write;
	logic [ADDR_W-1:0]   i_d_addr;
	logic [WORD_W-1:0]   i_d_wdata;
	logic [WORD_W-1:0]   o_d_rdata;
	logic                o_d_busy;

	// reference views: latest data, main memory, and both cache tag stores
	logic [WORD_W-1:0] ref_mem [MEM_DEPTH];
	logic [WORD_W-1:0] mem_model [MEM_DEPTH];
	logic              dc_valid [LINE_COUNT];
	logic              dc_dirty [LINE_COUNT];
	logic [TAG_W-1:0]  dc_tag [LINE_COUNT];
	logic              ic_valid [LINE_COUNT];
	logic [TAG_W-1:0]  ic_tag [LINE_COUNT];
	logic [WORD_W-1:0] ic_words [LINE_COUNT][LINE_WORDS];

	int errors;
	int tests;
	int test_errors;

	tb_clock u_clock (.o_clk(clk));

	mem_system u_mem_system (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_if_read (i_if_read),
		.i_if_addr (i_if_addr),
		.o_if_data (o_if_data),
		.o_if_busy (o_if_busy),
		.i_d_read  (i_d_read),
		.i_d_write (i_d_write),
		.i_d_addr  (i_d_addr),
		.i_d_wdata (i_d_wdata),
		.o_d_rdata (o_d_rdata),
		.o_d_busy  (o_d_busy)
	);

	bind mem_system mem_system_props u_props (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_gnt_ic   (u_arbiter.gnt_ic_q),
		.i_gnt_dc   (u_arbiter.gnt_dc_q),
		.i_mem_done (mem_done),
		.i_mem_cmd  (mem_cmd),
		.i_ic_state (u_icache.state_q),
		.i_dc_state (u_dcache.state_q),
		.i_if_read  (i_if_read),
		.i_d_read   (i_d_read),
		.i_d_write  (i_d_write),
		.i_if_busy  (o_if_busy),
		.i_d_busy   (o_d_busy)
	);

	task automatic check_dword(input string name, input logic [WORD_W-1:0] exp,
		input logic [WORD_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_iword(input string name, input logic [WORD_W-1:0] exp,
		input logic [WORD_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic report_flag(input string name, input string what, input bit bad);
		if (bad) begin
			$display("%s: %s", name, what);
			test_errors++;
		end
	endtask

	// data side mapping, victim goes back to memory on a dirty miss
	task automatic model_data(input logic [ADDR_W-1:0] addr, input logic wr,
		input logic [WORD_W-1:0] wdata);
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0]   tag;
		logic [7:0]         base;
		idx = addr[4:2];
		tag = addr[15:5];
		if (!(dc_valid[idx] && dc_tag[idx] == tag)) begin
			if (dc_valid[idx] && dc_dirty[idx]) begin
				base = {dc_tag[idx][2:0], idx, 2'b00};
				for (int w = 0; w < LINE_WORDS; w++) begin
					mem_model[base + 8'(w)] = ref_mem[base + 8'(w)];
				end
			end
			dc_valid[idx] = 1'b1;
			dc_tag[idx]   = tag;
			dc_dirty[idx] = 1'b0;
		end
		if (wr) begin
			ref_mem[addr[7:0]] = wdata;
			dc_dirty[idx]      = 1'b1;
		end
	endtask

	// instruction side sees memory as it was at refill time
	task automatic model_fetch(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] exp);
		logic [INDEX_W-1:0] idx;
		idx = addr[4:2];
		if (!(ic_valid[idx] && ic_tag[idx] == addr[15:5])) begin
			for (int w = 0; w < LINE_WORDS; w++) begin
				ic_words[idx][w] = mem_model[{addr[7:2], 2'(w)}];
			end
			ic_valid[idx] = 1'b1;
			ic_tag[idx]   = addr[15:5];
		end
		exp = ic_words[idx][addr[1:0]];
	endtask

	// entered and left 1 ns after a rising edge
	task automatic data_access(input string name, input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata, output bit waited);
		int n;
		n      = 0;
		waited = 0;
		i_d_read  = !wr;
		i_d_write = wr;
		i_d_addr  = addr;
		i_d_wdata = wdata;
		#1;
		while (o_d_busy && n < TIMEOUT) begin
			waited = 1;
			@(posedge clk);
			#2;
			n++;
		end
		report_flag(name, "data port stayed busy past the timeout", o_d_busy);
		@(posedge clk);
		#1;
		i_d_read  = 1'b0;
		i_d_write = 1'b0;
		rdata     = o_d_rdata;
		model_data(addr, wr, wdata);
	endtask

	task automatic fetch_access(input string name, input logic [ADDR_W-1:0] addr,
		output logic [WORD_W-1:0] data, output bit waited);
		int n;
		n      = 0;
		waited = 0;
		i_if_read = 1'b1;
		i_if_addr = addr;
		#1;
		while (o_if_busy && n < TIMEOUT) begin
			waited = 1;
			@(posedge clk);
			#2;
			n++;
		end
		report_flag(name, "instruction port stayed busy past the timeout", o_if_busy);
		@(posedge clk);
		#1;
		i_if_read = 1'b0;
		data      = o_if_data;
	endtask

	task automatic finish_test(input string name);
		tests++;
		errors += test_errors;
		$display("%s: %s", name, (test_errors == 0) ? "pass" : "fail");
		test_errors = 0;
	endtask

	task automatic test_reset_contents();
		logic [WORD_W-1:0] d;
		logic [WORD_W-1:0] e;
		bit w;
		report_flag("reset", "busy high with no request", o_if_busy || o_d_busy);
		data_access("reset", 1'b0, 16'h0000, '0, d, w);
		check_dword("reset data 0x00", 16'h0000, d);
		data_access("reset", 1'b0, 16'h00a5, '0, d, w);
		check_dword("reset data 0xa5", 16'h0000, d);
		model_fetch(16'h0010, e);
		fetch_access("reset", 16'h0010, d, w);
		check_iword("reset fetch 0x10", 16'h0000, d);
		model_fetch(16'h00f3, e);
		fetch_access("reset", 16'h00f3, d, w);
		check_iword("reset fetch 0xf3", 16'h0000, d);
		finish_test("reset");
	endtask

	task automatic test_write_read();
		logic [WORD_W-1:0] d;
		bit w;
		for (int i = 0; i < LINE_WORDS; i++) begin
			data_access("write_read", 1'b1, ADDR_W'(16'h0040 + i),
				WORD_W'(16'h3c00 + i), d, w);
		end
		for (int i = 0; i < LINE_WORDS; i++) begin
			data_access("write_read", 1'b0, ADDR_W'(16'h0040 + i), '0, d, w);
			check_dword("write_read", WORD_W'(16'h3c00 + i), d);
			report_flag("write_read", "busy rose on a read hit", w);
		end
		finish_test("write_read");
	endtask

	task automatic test_dirty_evict();
		logic [WORD_W-1:0] d;
		bit w;
		data_access("dirty_evict", 1'b1, 16'h0048, 16'h1234, d, w);
		data_access("dirty_evict", 1'b1, 16'h0068, 16'hbeef, d, w);
		data_access("dirty_evict", 1'b0, 16'h0048, '0, d, w);
		check_dword("dirty_evict", 16'h1234, d);
		finish_test("dirty_evict");
	endtask

	task automatic test_fetch_writeback();
		logic [WORD_W-1:0] d;
		logic [WORD_W-1:0] e;
		bit w;
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < LINE_WORDS; i++) begin
				model_fetch(ADDR_W'(16'h0048 + i), e);
				fetch_access("fetch_writeback", ADDR_W'(16'h0048 + i), d, w);
				check_iword("fetch_writeback", e, d);
				report_flag("fetch_writeback", "busy rose on a repeated fetch", pass == 1 && w);
			end
		end
		// word written on the data side before its line went back to memory
		fetch_access("fetch_writeback", 16'h0048, d, w);
		check_iword("fetch_writeback word 0", 16'h1234, d);
		finish_test("fetch_writeback");
	endtask

	task automatic test_concurrent();
		logic [WORD_W-1:0] d_data;
		logic [WORD_W-1:0] f_data;
		logic [WORD_W-1:0] e;
		bit d_done;
		bit f_done;
		bit d_go;
		bit f_go;
		int n;
		d_done = 0;
		f_done = 0;
		n      = 0;
		i_d_read  = 1'b1;
		i_d_addr  = 16'h0080;
		i_if_read = 1'b1;
		i_if_addr = 16'h00c4;
		#1;
		while (!(d_done && f_done) && n < TIMEOUT) begin
			d_go = !d_done && !o_d_busy;
			f_go = !f_done && !o_if_busy;
			@(posedge clk);
			#1;
			if (d_go) begin
				i_d_read = 1'b0;
				d_data   = o_d_rdata;
				d_done   = 1;
			end
			if (f_go) begin
				i_if_read = 1'b0;
				f_data    = o_if_data;
				f_done    = 1;
			end
			#1;
			n++;
		end
		report_flag("concurrent", "a port stayed busy past the timeout", !(d_done && f_done));
		i_d_read  = 1'b0;
		i_if_read = 1'b0;
		// data side holds the bus first on a tie
		model_data(16'h0080, 1'b0, '0);
		model_fetch(16'h00c4, e);
		check_dword("concurrent data", ref_mem[8'h80], d_data);
		check_iword("concurrent fetch", e, f_data);
		@(posedge clk);
		#1;
		finish_test("concurrent");
	endtask

	task automatic test_random();
		logic [WORD_W-1:0] d;
		logic [WORD_W-1:0] e;
		logic [ADDR_W-1:0] a;
		logic [WORD_W-1:0] wd;
		int op;
		bit w;
		for (int i = 0; i < 200; i++) begin
			op = $urandom % 3;
			a  = ADDR_W'($urandom % MEM_DEPTH);
			wd = WORD_W'($urandom);
			if (op == 0) begin
				data_access("random", 1'b1, a, wd, d, w);
			end else if (op == 1) begin
				data_access("random", 1'b0, a, '0, d, w);
				check_dword("random data", ref_mem[a[7:0]], d);
			end else begin
				model_fetch(a, e);
				fetch_access("random", a, d, w);
				check_iword("random fetch", e, d);
			end
		end
		finish_test("random");
	endtask

	initial begin
		void'($urandom(32'h5fe));
		reset_n     = 1'b0;
		i_if_read   = 1'b0;
		i_if_addr   = '0;
		i_d_read    = 1'b0;
		i_d_write   = 1'b0;
		i_d_addr    = '0;
		i_d_wdata   = '0;
		errors      = 0;
		tests       = 0;
		test_errors = 0;
		for (int i = 0; i < MEM_DEPTH; i++) begin
			ref_mem[i]   = '0;
			mem_model[i] = '0;
		end
		for (int i = 0; i < LINE_COUNT; i++) begin
			dc_valid[i] = 1'b0;
			dc_dirty[i] = 1'b0;
			ic_valid[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#1;
		reset_n = 1'b1;
		@(posedge clk);
		#1;
		test_reset_contents();
		test_write_read();
		test_dirty_evict();
		test_fetch_writeback();
		test_concurrent();
		test_random();
		$display("tests run %0d, failed checks %0d", tests, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
cache_pkg.sv
icache.sv
dcache.sv
mem_arbiter.sv
main_memory.sv
mem_system.sv
tb_clock.sv
mem_system_props.sv
tb_mem_system.sv

/* run.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert -f list.f --top-module tb_mem_system -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
grep -q "ALL TESTS PASSED" sim.log
